// ==== verilog/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// bus widths
`define CACHE_ADDR_W      32
`define CACHE_DATA_W      32

// address split into tag, index and offset
`define CACHE_TAG_W       24
`define CACHE_INDEX_W     4
// two word-select bits plus two byte bits
`define CACHE_OFFSET_W    4

// organisation
`define CACHE_WAYS        4
`define CACHE_WAY_W       2
`define CACHE_LINE_WORDS  4
`define CACHE_SETS        16

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_W-1:0]                 tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]               index_t;
    typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0]    word_sel_t;
    typedef logic [`CACHE_WAY_W-1:0]                 way_t;

    // 0 is most recent, ways-1 is the next victim
    typedef logic [`CACHE_WAY_W-1:0]                 lru_age_t;

    // processor byte address split into its fields
    typedef struct packed {
        tag_t                                                tag;
        index_t                                              index;
        word_sel_t                                           word_sel;
        logic [`CACHE_OFFSET_W-$clog2(`CACHE_LINE_WORDS)-1:0] byte_sel;
    } cpu_addr_t;

    // one looked-up access handed to the fill stage
    typedef struct packed {
        logic                       we;
        tag_t                       tag;
        index_t                     index;
        word_sel_t                  word_sel;
        logic [`CACHE_DATA_W-1:0]   wdata;
        logic                       hit;
        way_t                       way;            // hit way, or victim on a miss
        logic                       victim_dirty;
        tag_t                       victim_tag;
    } lookup_req_t;

endpackage

// ==== verilog/stage_if.sv ====
`timescale 1ns/1ps

interface stage_if;
    import cache_pkg::*;

    // request from the tag lookup stage, held until after done
    logic        valid;
    lookup_req_t req;

    // one-cycle pulse when the processor access is acked
    logic        done;

    modport lookup
    (
        output valid,
        output req,
        input  done
    );

    modport fill
    (
        input  valid,
        input  req,
        output done
    );

endinterface

// ==== verilog/tag_lookup_stage.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_lookup_stage
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cpu_cyc,
    input  logic                      cpu_stb,
    input  logic                      cpu_we,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_adr,
    input  logic [`CACHE_DATA_W-1:0]  cpu_dat_w,
    stage_if.lookup                   out
);
    import cache_pkg::*;

    // tag state per set and way
    tag_t     tag_mem    [`CACHE_SETS][`CACHE_WAYS];
    logic     valid_bits [`CACHE_SETS][`CACHE_WAYS];
    logic     dirty_bits [`CACHE_SETS][`CACHE_WAYS];
    lru_age_t lru_age    [`CACHE_SETS][`CACHE_WAYS];

    cpu_addr_t               addr_f;
    logic [`CACHE_WAYS-1:0]  hit_vec;
    logic                    hit;
    way_t                    hit_way;
    way_t                    victim_way;
    way_t                    use_way;
    lru_age_t                use_age;
    logic                    start;
    lookup_req_t             next_req;

    assign addr_f = cpu_adr;

    // one access at a time, so only accept while nothing is in flight
    assign start = !out.valid && cpu_cyc && cpu_stb;

    always_comb
    begin
        hit_way    = '0;
        victim_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            hit_vec[w] = valid_bits[addr_f.index][w] &&
                         (tag_mem[addr_f.index][w] == addr_f.tag);
            if (hit_vec[w])
                hit_way = way_t'(w);
            // oldest way in the set
            if (lru_age[addr_f.index][w] == lru_age_t'(`CACHE_WAYS - 1))
                victim_way = way_t'(w);
        end
    end

    assign hit     = |hit_vec;
    assign use_way = hit ? hit_way : victim_way;
    assign use_age = lru_age[addr_f.index][use_way];

    always_comb
    begin
        next_req.we           = cpu_we;
        next_req.tag          = addr_f.tag;
        next_req.index        = addr_f.index;
        next_req.word_sel     = addr_f.word_sel;
        next_req.wdata        = cpu_dat_w;
        next_req.hit          = hit;
        next_req.way          = use_way;
        // old state of the victim, before this edge overwrites it
        next_req.victim_dirty = !hit && valid_bits[addr_f.index][victim_way] &&
                                dirty_bits[addr_f.index][victim_way];
        next_req.victim_tag   = tag_mem[addr_f.index][victim_way];
    end

    // request payload and tags
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            out.req <= next_req;
            if (!hit)
                tag_mem[addr_f.index][victim_way] <= addr_f.tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out.valid <= 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++)
            begin
                for (int w = 0; w < `CACHE_WAYS; w++)
                begin
                    valid_bits[s][w] <= 1'b0;
                    dirty_bits[s][w] <= 1'b0;
                    lru_age[s][w]    <= lru_age_t'(w);
                end
            end
        end
        else if (out.done)
        begin
            out.valid <= 1'b0;
        end
        else if (start)
        begin
            out.valid <= 1'b1;
            valid_bits[addr_f.index][use_way] <= 1'b1;
            if (!hit)
                dirty_bits[addr_f.index][use_way] <= cpu_we;
            else if (cpu_we)
                dirty_bits[addr_f.index][use_way] <= 1'b1;

            // chosen way becomes newest, younger ways age by one
            for (int w = 0; w < `CACHE_WAYS; w++)
            begin
                if (way_t'(w) == use_way)
                    lru_age[addr_f.index][w] <= '0;
                else if (lru_age[addr_f.index][w] < use_age)
                    lru_age[addr_f.index][w] <= lru_age[addr_f.index][w] + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/line_fill_stage.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_fill_stage
(
    input  logic                      clk,
    input  logic                      reset,
    stage_if.fill                     in,
    output logic [`CACHE_DATA_W-1:0]  cpu_dat_r,
    output logic                      cpu_ack,
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output logic                      mem_we,
    output logic [`CACHE_ADDR_W-1:0]  mem_adr,
    output logic [`CACHE_DATA_W-1:0]  mem_dat_w,
    input  logic [`CACHE_DATA_W-1:0]  mem_dat_r,
    input  logic                      mem_ack
);
    import cache_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        WRITE_BACK,
        REFILL,
        FINISH
    } fill_state_t;

    localparam int ENTRIES = `CACHE_SETS * `CACHE_WAYS * `CACHE_LINE_WORDS;
    localparam int ENTRY_W = `CACHE_INDEX_W + `CACHE_WAY_W + $bits(word_sel_t);
    localparam int BYTE_W  = `CACHE_OFFSET_W - $bits(word_sel_t);

    fill_state_t              state;
    word_sel_t                word_cnt;
    logic                     last_word;

    // flat array addressed by {set, way, word}
    logic [`CACHE_DATA_W-1:0] data_mem [ENTRIES];
    logic [ENTRY_W-1:0]       cnt_entry;
    logic [ENTRY_W-1:0]       req_entry;

    assign cnt_entry = {in.req.index, in.req.way, word_cnt};
    assign req_entry = {in.req.index, in.req.way, in.req.word_sel};
    assign last_word = (word_cnt == word_sel_t'(`CACHE_LINE_WORDS - 1));

    // processor side
    assign cpu_ack   = (state == FINISH);
    assign in.done   = (state == FINISH);
    assign cpu_dat_r = data_mem[req_entry];

    // memory side outputs hold until mem_ack
    always_comb
    begin
        mem_cyc   = (state == WRITE_BACK) || (state == REFILL);
        mem_stb   = mem_cyc;
        mem_we    = (state == WRITE_BACK);
        mem_dat_w = data_mem[cnt_entry];
        if (state == WRITE_BACK)
            mem_adr = {in.req.victim_tag, in.req.index, word_cnt, {BYTE_W{1'b0}}};
        else
            mem_adr = {in.req.tag, in.req.index, word_cnt, {BYTE_W{1'b0}}};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= IDLE;
            word_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    word_cnt <= '0;
                    if (in.valid)
                    begin
                        if (in.req.hit)
                            state <= FINISH;
                        else if (in.req.victim_dirty)
                            state <= WRITE_BACK;
                        else
                            state <= REFILL;
                    end
                end
                WRITE_BACK:
                begin
                    if (mem_ack)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        // counter wraps to 0 for the refill
                        if (last_word)
                            state <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (mem_ack)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word)
                            state <= FINISH;
                    end
                end
                FINISH:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // refill words land as they arrive, the store merges in at the end
    always_ff @(posedge clk)
    begin
        if (state == REFILL && mem_ack)
            data_mem[cnt_entry] <= mem_dat_r;
        else if (state == FINISH && in.req.we)
            data_mem[req_entry] <= in.req.wdata;
    end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top
(
    input  logic                      clk,
    input  logic                      reset,

    // processor side, Wishbone classic slave
    input  logic                      cpu_cyc,
    input  logic                      cpu_stb,
    input  logic                      cpu_we,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_adr,
    input  logic [`CACHE_DATA_W-1:0]  cpu_dat_w,
    output logic [`CACHE_DATA_W-1:0]  cpu_dat_r,
    output logic                      cpu_ack,

    // memory side, Wishbone classic master
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output logic                      mem_we,
    output logic [`CACHE_ADDR_W-1:0]  mem_adr,
    output logic [`CACHE_DATA_W-1:0]  mem_dat_w,
    input  logic [`CACHE_DATA_W-1:0]  mem_dat_r,
    input  logic                      mem_ack
);

    stage_if i_stage ();

    tag_lookup_stage i_lookup
    (
        .clk       (clk),
        .reset     (reset),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .out       (i_stage.lookup)
    );

    line_fill_stage i_fill
    (
        .clk       (clk),
        .reset     (reset),
        .in        (i_stage.fill),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // reset drops 1 ns after the last reset edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb;

    localparam int MEM_WORDS   = 4096;
    localparam int ACK_TIMEOUT = 200;

    logic                      clk;
    logic                      reset;
    logic                      cpu_cyc;
    logic                      cpu_stb;
    logic                      cpu_we;
    logic [`CACHE_ADDR_W-1:0]  cpu_adr;
    logic [`CACHE_DATA_W-1:0]  cpu_dat_w;
    logic [`CACHE_DATA_W-1:0]  cpu_dat_r;
    logic                      cpu_ack;
    logic                      mem_cyc;
    logic                      mem_stb;
    logic                      mem_we;
    logic [`CACHE_ADDR_W-1:0]  mem_adr;
    logic [`CACHE_DATA_W-1:0]  mem_dat_w;
    logic [`CACHE_DATA_W-1:0]  mem_dat_r = '0;
    logic                      mem_ack = 1'b0;

    // memory model state and its access log
    logic [31:0] mem_words [MEM_WORDS];
    logic        mem_pending = 1'b0;
    logic        log_we  [$];
    logic [31:0] log_adr [$];
    logic [31:0] log_dat [$];

    // reference model of word values and shadow tag state
    logic [31:0] ref_words [MEM_WORDS];
    logic [23:0] sh_tag   [16][4];
    logic        sh_valid [16][4];
    logic        sh_dirty [16][4];
    int          sh_age   [16][4];

    int seed;

    tb_clock_gen i_clk_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    cache_top i_dut
    (
        .clk       (clk),
        .reset     (reset),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    function automatic logic [31:0] init_value(input logic [31:0] adr);
        return adr ^ 32'h5a5a_0000;
    endfunction

    function automatic int word_index(input logic [31:0] adr);
        return int'(adr[13:2]);
    endfunction

    function automatic logic [31:0] line_adr(input int tag, input int set);
        return (tag << 8) | (set << 4);
    endfunction

    // acks each strobe one cycle after it is seen
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            mem_ack     = 1'b0;
            mem_pending = 1'b0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem_words[i] = init_value(i * 4);
        end
        else if (mem_ack)
        begin
            mem_ack     = 1'b0;
            mem_pending = 1'b0;
        end
        else if (mem_pending)
        begin
            log_we.push_back(mem_we);
            log_adr.push_back(mem_adr);
            log_dat.push_back(mem_dat_w);
            if (mem_we)
                mem_words[word_index(mem_adr)] = mem_dat_w;
            else
                mem_dat_r = mem_words[word_index(mem_adr)];
            mem_ack = 1'b1;
        end
        else if (mem_cyc && mem_stb)
        begin
            mem_pending = 1'b1;
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp)
        else
            stop_run($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
                               $time, what, got, exp));
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        while (reset !== 1'b0)
        begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 100)
                stop_run("reset was never released");
        end
    endtask

    // one classic cycle on the processor bus
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output int cycles);
        @(posedge clk);
        #1;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_dat_w = wdata;
        cycles    = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT)
                stop_run($sformatf("no cpu_ack within %0d cycles for address %h",
                                   ACK_TIMEOUT, adr));
        end
        while (!cpu_ack);
        rdata = cpu_dat_r;
        @(posedge clk);
        #1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
    endtask

    // hit or victim from the shadow tags, then update them like the cache does
    task automatic predict_access(input logic we, input logic [31:0] adr,
                                  output int exp_writes, output logic [31:0] wb_base,
                                  output int exp_reads, output logic [31:0] rf_base);
        logic [23:0] tag;
        int          set;
        int          way;
        int          old_age;
        tag        = adr[31:8];
        set        = int'(adr[7:4]);
        way        = -1;
        exp_writes = 0;
        exp_reads  = 0;
        wb_base    = '0;
        rf_base    = {adr[31:4], 4'h0};
        for (int w = 0; w < 4; w++)
        begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag)
                way = w;
        end
        if (way < 0)
        begin
            for (int w = 0; w < 4; w++)
            begin
                if (sh_age[set][w] == 3)
                    way = w;
            end
            if (sh_valid[set][way] && sh_dirty[set][way])
            begin
                exp_writes = 4;
                wb_base    = {sh_tag[set][way], adr[7:4], 4'h0};
            end
            exp_reads          = 4;
            sh_tag[set][way]   = tag;
            sh_valid[set][way] = 1'b1;
            sh_dirty[set][way] = we;
        end
        else if (we)
        begin
            sh_dirty[set][way] = 1'b1;
        end
        old_age = sh_age[set][way];
        for (int w = 0; w < 4; w++)
        begin
            if (w == way)
                sh_age[set][w] = 0;
            else if (sh_age[set][w] < old_age)
                sh_age[set][w]++;
        end
    endtask

    // access, then compare read data and memory traffic with the reference model
    task automatic access_and_check(input logic we, input logic [31:0] adr,
                                    input logic [31:0] wdata,
                                    output logic [31:0] rdata, output int cycles);
        int          exp_writes;
        int          exp_reads;
        logic [31:0] wb_base;
        logic [31:0] rf_base;
        int          pos;
        predict_access(we, adr, exp_writes, wb_base, exp_reads, rf_base);
        log_we.delete();
        log_adr.delete();
        log_dat.delete();
        bus_cycle(we, adr, wdata, rdata, cycles);
        if (!we)
            check_value(rdata, ref_words[word_index(adr)], $sformatf("read data at %h", adr));
        check_value(log_we.size(), exp_writes + exp_reads,
                    $sformatf("memory access count for %h", adr));
        for (int i = 0; i < exp_writes; i++)
        begin
            check_value(log_we[i], 1'b1, "write-back direction");
            check_value(log_adr[i], wb_base + 4 * i, "write-back address");
            check_value(log_dat[i], ref_words[word_index(wb_base) + i], "write-back data");
        end
        for (int i = 0; i < exp_reads; i++)
        begin
            pos = exp_writes + i;
            check_value(log_we[pos], 1'b0, "refill direction");
            check_value(log_adr[pos], rf_base + 4 * i, "refill address");
        end
        if (we)
            ref_words[word_index(adr)] = wdata;
    endtask

    task automatic read_miss_refill();
        logic [31:0] rdata;
        int          cycles;
        access_and_check(1'b0, 32'h0000_0100, '0, rdata, cycles);
        check_value(rdata, init_value(32'h0000_0100), "first read after reset");
        check_value(log_we.size(), 4, "refill read count");
    endtask

    task automatic read_hit_latency();
        logic [31:0] rdata;
        int          cycles;
        access_and_check(1'b0, 32'h0000_0108, '0, rdata, cycles);
        check_value(rdata, init_value(32'h0000_0108), "read hit data");
        check_value(cycles, 2, "cycles from strobe to cpu_ack on a hit");
        check_value(log_we.size(), 0, "memory traffic on a hit");
    endtask

    task automatic write_hit_deferral();
        logic [31:0] rdata;
        int          cycles;
        access_and_check(1'b1, 32'h0000_0104, 32'hdead_beef, rdata, cycles);
        check_value(log_we.size(), 0, "memory traffic on a write hit");
        access_and_check(1'b0, 32'h0000_0104, '0, rdata, cycles);
        check_value(rdata, 32'hdead_beef, "read after write hit");
        check_value(mem_words[word_index(32'h0000_0104)], init_value(32'h0000_0104),
                    "memory word before write-back");
    endtask

    task automatic lru_eviction();
        logic [31:0] rdata;
        int          cycles;
        // dirty the first line, then fill the other three ways of set 3
        access_and_check(1'b1, line_adr(2, 3) + 4, 32'h1234_5678, rdata, cycles);
        for (int t = 3; t <= 5; t++)
            access_and_check(1'b0, line_adr(t, 3), '0, rdata, cycles);
        access_and_check(1'b0, line_adr(6, 3) + 8, '0, rdata, cycles);
        check_value(log_we.size(), 8, "traffic of the evicting access");
        check_value(log_adr[0], line_adr(2, 3), "victim line base");
        check_value(mem_words[word_index(line_adr(2, 3) + 4)], 32'h1234_5678,
                    "memory after write-back");
        access_and_check(1'b0, line_adr(2, 3) + 4, '0, rdata, cycles);
        check_value(rdata, 32'h1234_5678, "re-read of the evicted word");
    endtask

    task automatic random_mix();
        int          sets [3];
        int          set;
        int          tag;
        int          word;
        logic        we;
        logic [31:0] wdata;
        logic [31:0] rdata;
        int          cycles;
        sets = '{1, 5, 9};
        for (int n = 0; n < 60; n++)
        begin
            set   = sets[$unsigned($random(seed)) % 3];
            tag   = 8 + $unsigned($random(seed)) % 8;
            word  = $unsigned($random(seed)) % 4;
            we    = 1'($unsigned($random(seed)) % 2);
            wdata = $random(seed);
            access_and_check(we, line_adr(tag, set) + 4 * word, wdata, rdata, cycles);
        end
    endtask

    initial
    begin
        cpu_cyc    = 1'b0;
        cpu_stb    = 1'b0;
        cpu_we     = 1'b0;
        cpu_adr    = '0;
        cpu_dat_w  = '0;
        seed       = 32'ha49c;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_words[i] = init_value(i * 4);
        // way 3 is the oldest after reset
        for (int s = 0; s < 16; s++)
        begin
            for (int w = 0; w < 4; w++)
            begin
                sh_tag[s][w]   = '0;
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_age[s][w]   = w;
            end
        end
        wait_reset_release();
        read_miss_refill();
        read_hit_latency();
        write_hit_deferral();
        lru_eviction();
        random_mix();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/stage_if.sv
verilog/tag_lookup_stage.sv
verilog/line_fill_stage.sv
verilog/cache_top.sv
tests/tb_clock_gen.sv
tests/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
